// File: hw/spw_tx_pkg.sv
package spw_tx_pkg;

	// --------------------------------------------------
	// Character kinds and link phases
	// --------------------------------------------------
	typedef enum logic [2:0] {
		CHAR_NULL,
		CHAR_FCT,
		CHAR_DATA,
		CHAR_EOP,
		CHAR_EEP
	} spw_char_e;

	typedef enum logic [1:0] {
		PHASE_START,
		PHASE_NULLS,
		PHASE_NULL_FCT,
		PHASE_RUN
	} spw_phase_e;

	// --------------------------------------------------
	// Character lengths in line bits
	// --------------------------------------------------
	localparam int BIT_CNT_W = 4;
	localparam int CHAR_MAX_W = 10;

	localparam logic [BIT_CNT_W-1:0] CHAR_LEN_NULL = 4'd8;
	localparam logic [BIT_CNT_W-1:0] CHAR_LEN_CTRL = 4'd4;
	localparam logic [BIT_CNT_W-1:0] CHAR_LEN_DATA = 4'd10;

	// Control codes, sent low bit first after the flag
	localparam logic [1:0] CTRL_FCT = 2'b00;
	localparam logic [1:0] CTRL_EOP = 2'b01;
	localparam logic [1:0] CTRL_EEP = 2'b10;
	localparam logic [1:0] CTRL_ESC = 2'b11;

	// Host word, bit 8 marks EOP or EEP
	localparam int NCHAR_W = 9;

	// --------------------------------------------------
	// Flow control
	// --------------------------------------------------
	localparam int CREDIT_W = 6;
	localparam int FCT_OUT_W = 3;

	localparam logic [CREDIT_W-1:0] CREDIT_PER_FCT = 6'd8;
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = 6'd56;
	localparam logic [FCT_OUT_W-1:0] FCT_OUT_MAX = 3'd7;

endpackage

// File: hw/spw_tx_link_fsm.sv
`timescale 1ns/1ps

module spw_tx_link_fsm import spw_tx_pkg::*; (
	input  logic       pclk_tx,
	input  logic       enable_tx,
	input  logic       send_null_tx_i,
	input  logic       send_fct_tx_i,
	input  logic       credit_avail_i,
	input  logic       char_done_i,
	output spw_phase_e phase_o
);

	spw_phase_e phase_q;
	spw_phase_e phase_next;

	// --------------------------------------------------
	// Next phase
	// --------------------------------------------------
	always_comb
	begin
		phase_next = phase_q;
		if (!send_null_tx_i)
		begin
			phase_next = PHASE_START;
		end
		else
		begin
			case (phase_q)
				PHASE_START:
				begin
					phase_next = PHASE_NULLS;
				end
				PHASE_NULLS:
				begin
					if (char_done_i && send_fct_tx_i)
						phase_next = PHASE_NULL_FCT;
				end
				PHASE_NULL_FCT:
				begin
					// Needs credit from the far end before data may flow
					if (char_done_i && send_fct_tx_i && credit_avail_i)
						phase_next = PHASE_RUN;
				end
				default:
				begin
					phase_next = PHASE_RUN;
				end
			endcase
		end
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			phase_q <= PHASE_START;
		end
		else
		begin
			phase_q <= phase_next;
		end
	end

	assign phase_o = phase_q;

endmodule

// File: hw/spw_tx_credit.sv
`timescale 1ns/1ps

module spw_tx_credit import spw_tx_pkg::*; (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic gotfct_tx_i,
	input  logic send_fct_now_i,
	input  logic sent_nchar_i,
	input  logic sent_fct_i,
	output logic credit_avail_o,
	output logic fct_pending_o
);

	logic                 gotfct_q;
	logic                 fct_now_q;
	logic                 gotfct_rise;
	logic                 fct_req_rise;
	logic [CREDIT_W-1:0]  credit_q;
	logic [FCT_OUT_W-1:0] fct_out_q;
	logic [CREDIT_W:0]    credit_sum;
	logic [FCT_OUT_W:0]   fct_out_sum;

	// A held level counts once
	assign gotfct_rise  = gotfct_tx_i & ~gotfct_q;
	assign fct_req_rise = send_fct_now_i & ~fct_now_q;

	// --------------------------------------------------
	// Transmit credit
	// --------------------------------------------------
	always_comb
	begin
		credit_sum = {1'b0, credit_q};
		if (gotfct_rise)
			credit_sum = credit_sum + {1'b0, CREDIT_PER_FCT};
		if (sent_nchar_i)
			credit_sum = credit_sum - 1'b1;
		if (credit_sum > {1'b0, CREDIT_MAX})
			credit_sum = {1'b0, CREDIT_MAX};
	end

	// --------------------------------------------------
	// FCTs owed to the far end
	// --------------------------------------------------
	always_comb
	begin
		fct_out_sum = {1'b0, fct_out_q};
		if (fct_req_rise)
			fct_out_sum = fct_out_sum + 1'b1;
		if (sent_fct_i)
			fct_out_sum = fct_out_sum - 1'b1;
		if (fct_out_sum > {1'b0, FCT_OUT_MAX})
			fct_out_sum = {1'b0, FCT_OUT_MAX};
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			gotfct_q  <= 1'b0;
			fct_now_q <= 1'b0;
			credit_q  <= '0;
			fct_out_q <= '0;
		end
		else
		begin
			gotfct_q  <= gotfct_tx_i;
			fct_now_q <= send_fct_now_i;
			credit_q  <= credit_sum[CREDIT_W-1:0];
			fct_out_q <= fct_out_sum[FCT_OUT_W-1:0];
		end
	end

	assign credit_avail_o = (credit_q != '0);
	assign fct_pending_o  = (fct_out_q != '0);

endmodule

// File: hw/spw_tx_char_select.sv
`timescale 1ns/1ps

module spw_tx_char_select import spw_tx_pkg::*; (
	input  logic               pclk_tx,
	input  logic               enable_tx,
	input  spw_phase_e         phase_i,
	input  logic               char_done_i,
	input  logic               txwrite_tx_i,
	input  logic [NCHAR_W-1:0] data_tx_i,
	input  logic               credit_avail_i,
	input  logic               fct_pending_i,
	output logic               load_o,
	output spw_char_e          next_kind_o,
	output logic [7:0]         next_byte_o,
	output logic               sent_nchar_o,
	output logic               sent_fct_o,
	output logic               ready_tx_data_o
);

	spw_phase_e phase_q;
	spw_char_e  nchar_kind;
	logic       link_start;
	logic       boundary;
	logic       fct_allowed;
	logic       take_fct;
	logic       take_nchar;

	// Previous phase, to find the first cycle of NULLS
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			phase_q <= PHASE_START;
		end
		else
		begin
			phase_q <= phase_i;
		end
	end

	assign link_start = (phase_i == PHASE_NULLS) && (phase_q == PHASE_START);
	assign boundary   = (phase_i != PHASE_START) && (char_done_i || link_start);

	// --------------------------------------------------
	// Priority: FCT, then N-char, then NULL
	// --------------------------------------------------
	assign fct_allowed = (phase_i == PHASE_NULL_FCT) || (phase_i == PHASE_RUN);
	assign take_fct    = fct_allowed && fct_pending_i;
	assign take_nchar  = (phase_i == PHASE_RUN) && !fct_pending_i &&
	                     txwrite_tx_i && credit_avail_i;

	always_comb
	begin
		if (!data_tx_i[8])
			nchar_kind = CHAR_DATA;
		else if (data_tx_i[1:0] == 2'b00)
			nchar_kind = CHAR_EOP;
		else
			nchar_kind = CHAR_EEP;
	end

	always_comb
	begin
		if (take_fct)
			next_kind_o = CHAR_FCT;
		else if (take_nchar)
			next_kind_o = nchar_kind;
		else
			next_kind_o = CHAR_NULL;
	end

	assign next_byte_o = take_nchar ? data_tx_i[7:0] : 8'h00;

	// Strobes for the serializer, credit block and host
	assign load_o          = boundary;
	assign sent_fct_o      = boundary && take_fct;
	assign sent_nchar_o    = boundary && take_nchar;
	assign ready_tx_data_o = boundary && take_nchar;

endmodule

// File: hw/spw_tx_serializer.sv
`timescale 1ns/1ps

module spw_tx_serializer import spw_tx_pkg::*; (
	input  logic       pclk_tx,
	input  logic       enable_tx,
	input  logic       send_null_tx_i,
	input  logic       load_i,
	input  spw_char_e  next_kind_i,
	input  logic [7:0] next_byte_i,
	output logic       line_bit_o,
	output logic       line_valid_o,
	output logic       char_done_o
);

	logic [CHAR_MAX_W-1:0] shift_q;
	logic [CHAR_MAX_W-1:0] char_vec;
	logic [BIT_CNT_W-1:0]  bit_cnt_q;
	logic [BIT_CNT_W-1:0]  char_len;
	logic [1:0]            ctrl_code;
	logic                  busy_q;
	logic                  par_prev_q;
	logic                  par_next;
	logic                  flag;
	logic                  par_bit;
	logic                  null_par;

	// --------------------------------------------------
	// Parity
	// --------------------------------------------------
	assign flag    = (next_kind_i != CHAR_DATA);
	assign par_bit = ~(par_prev_q ^ flag);

	// FCT half of a NULL covers the ESC code bits
	assign null_par = ~(^CTRL_ESC ^ 1'b1);

	always_comb
	begin
		case (next_kind_i)
			CHAR_EOP: ctrl_code = CTRL_EOP;
			CHAR_EEP: ctrl_code = CTRL_EEP;
			default:  ctrl_code = CTRL_FCT;
		endcase
	end

	// Bit 0 of char_vec goes on the line first
	always_comb
	begin
		case (next_kind_i)
			CHAR_DATA:
			begin
				char_vec = {next_byte_i, 1'b0, par_bit};
				char_len = CHAR_LEN_DATA;
				par_next = ^next_byte_i;
			end
			CHAR_NULL:
			begin
				char_vec = {{(CHAR_MAX_W - 8){1'b0}}, CTRL_FCT, 1'b1, null_par,
				            CTRL_ESC, 1'b1, par_bit};
				char_len = CHAR_LEN_NULL;
				par_next = ^CTRL_FCT;
			end
			default:
			begin
				char_vec = {{(CHAR_MAX_W - 4){1'b0}}, ctrl_code, 1'b1, par_bit};
				char_len = CHAR_LEN_CTRL;
				par_next = ^ctrl_code;
			end
		endcase
	end

	// --------------------------------------------------
	// Bit sequencing
	// --------------------------------------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			busy_q     <= 1'b0;
			bit_cnt_q  <= '0;
			par_prev_q <= 1'b0;
		end
		else if (!send_null_tx_i)
		begin
			// Link dropped, start over with clean parity
			busy_q     <= 1'b0;
			bit_cnt_q  <= '0;
			par_prev_q <= 1'b0;
		end
		else if (load_i)
		begin
			busy_q     <= 1'b1;
			bit_cnt_q  <= char_len - 1'b1;
			par_prev_q <= par_next;
		end
		else if (busy_q)
		begin
			if (bit_cnt_q == '0)
				busy_q <= 1'b0;
			else
				bit_cnt_q <= bit_cnt_q - 1'b1;
		end
	end

	always_ff @(posedge pclk_tx)
	begin
		if (load_i)
			shift_q <= char_vec;
		else
			shift_q <= shift_q >> 1;
	end

	assign line_bit_o   = shift_q[0];
	assign line_valid_o = busy_q;
	assign char_done_o  = busy_q && (bit_cnt_q == '0);

endmodule

// File: hw/spw_tx_ds_encoder.sv
`timescale 1ns/1ps

module spw_tx_ds_encoder (
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic line_bit_i,
	input  logic line_valid_i,
	output logic tx_dout_o,
	output logic tx_sout_o
);

	logic d_q;
	logic s_q;

	// Strobe toggles only when data repeats
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			d_q <= 1'b0;
			s_q <= 1'b0;
		end
		else if (!line_valid_i)
		begin
			d_q <= 1'b0;
			s_q <= 1'b0;
		end
		else
		begin
			d_q <= line_bit_i;
			if (line_bit_i == d_q)
				s_q <= ~s_q;
		end
	end

	assign tx_dout_o = d_q;
	assign tx_sout_o = s_q;

endmodule

// File: hw/spw_tx.sv
`timescale 1ns/1ps

module spw_tx import spw_tx_pkg::*; (
	input  logic               pclk_tx,
	input  logic               enable_tx,
	input  logic [NCHAR_W-1:0] data_tx_i,
	input  logic               txwrite_tx_i,
	input  logic               send_null_tx_i,
	input  logic               send_fct_tx_i,
	input  logic               gotfct_tx_i,
	input  logic               send_fct_now_i,
	output logic               tx_dout_o,
	output logic               tx_sout_o,
	output logic               ready_tx_data_o
);

	spw_phase_e phase;
	spw_char_e  next_kind;
	logic [7:0] next_byte;
	logic       char_done;
	logic       load;
	logic       sent_nchar;
	logic       sent_fct;
	logic       credit_avail;
	logic       fct_pending;
	logic       line_bit;
	logic       line_valid;

	spw_tx_link_fsm i_link_fsm (
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.send_null_tx_i (send_null_tx_i),
		.send_fct_tx_i  (send_fct_tx_i),
		.credit_avail_i (credit_avail),
		.char_done_i    (char_done),
		.phase_o        (phase)
	);

	spw_tx_credit i_credit (
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.gotfct_tx_i    (gotfct_tx_i),
		.send_fct_now_i (send_fct_now_i),
		.sent_nchar_i   (sent_nchar),
		.sent_fct_i     (sent_fct),
		.credit_avail_o (credit_avail),
		.fct_pending_o  (fct_pending)
	);

	spw_tx_char_select i_char_select (
		.pclk_tx         (pclk_tx),
		.enable_tx       (enable_tx),
		.phase_i         (phase),
		.char_done_i     (char_done),
		.txwrite_tx_i    (txwrite_tx_i),
		.data_tx_i       (data_tx_i),
		.credit_avail_i  (credit_avail),
		.fct_pending_i   (fct_pending),
		.load_o          (load),
		.next_kind_o     (next_kind),
		.next_byte_o     (next_byte),
		.sent_nchar_o    (sent_nchar),
		.sent_fct_o      (sent_fct),
		.ready_tx_data_o (ready_tx_data_o)
	);

	spw_tx_serializer i_serializer (
		.pclk_tx        (pclk_tx),
		.enable_tx      (enable_tx),
		.send_null_tx_i (send_null_tx_i),
		.load_i         (load),
		.next_kind_i    (next_kind),
		.next_byte_i    (next_byte),
		.line_bit_o     (line_bit),
		.line_valid_o   (line_valid),
		.char_done_o    (char_done)
	);

	spw_tx_ds_encoder i_ds_encoder (
		.pclk_tx      (pclk_tx),
		.enable_tx    (enable_tx),
		.line_bit_i   (line_bit),
		.line_valid_i (line_valid),
		.tx_dout_o    (tx_dout_o),
		.tx_sout_o    (tx_sout_o)
	);

endmodule

// File: verification/tb_spw_tx.sv
`timescale 1ns/1ps

module tb_spw_tx import spw_tx_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	// Characters expected on the line over all tests
	localparam int TEST_CHARS = 4 + 16 + 40 + 20 + 100 + 6;
	localparam int WATCHDOG_NS = TEST_CHARS * int'(CHAR_LEN_DATA) * CLK_PERIOD * 2;

	logic               pclk_tx;
	logic               enable_tx;
	logic [NCHAR_W-1:0] data_tx_i;
	logic               txwrite_tx_i;
	logic               send_null_tx_i;
	logic               send_fct_tx_i;
	logic               gotfct_tx_i;
	logic               send_fct_now_i;
	logic               tx_dout_o;
	logic               tx_sout_o;
	logic               ready_tx_data_o;

	logic       decode_en;
	logic       prev_d;
	logic       prev_s;
	logic       d_chg;
	logic       s_chg;
	logic       started;
	logic       esc_seen;
	logic       run_par;
	logic       flag;
	logic [9:0] cbuf;
	logic [1:0] code;
	int         nbits;
	int         need;
	int         char_total;
	int         ready_cnt;
	int         error_count;
	int         tests_passed;
	int         tests_failed;
	int         seed_val;
	spw_char_e  kind_q[$];
	logic [7:0] byte_q[$];

	spw_tx i_dut (
		.pclk_tx         (pclk_tx),
		.enable_tx       (enable_tx),
		.data_tx_i       (data_tx_i),
		.txwrite_tx_i    (txwrite_tx_i),
		.send_null_tx_i  (send_null_tx_i),
		.send_fct_tx_i   (send_fct_tx_i),
		.gotfct_tx_i     (gotfct_tx_i),
		.send_fct_now_i  (send_fct_now_i),
		.tx_dout_o       (tx_dout_o),
		.tx_sout_o       (tx_sout_o),
		.ready_tx_data_o (ready_tx_data_o)
	);

	initial
	begin
		pclk_tx = 1'b0;
		forever #(CLK_PERIOD / 2) pclk_tx = ~pclk_tx;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("ERRORS FOUND");
		$finish;
	end

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_kind(input string name, input spw_char_e got, input spw_char_e exp);
		if (got !== exp)
		begin
			$display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_count(input string name, input logic [CREDIT_W-1:0] got,
	                           input logic [CREDIT_W-1:0] exp);
		if (got !== exp)
		begin
			$display("error %s: got 0x%0h expected 0x%0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("failure: %s", what);
		error_count++;
	endtask

	function automatic logic [CREDIT_W-1:0] to_count(input int n);
		return n[CREDIT_W-1:0];
	endfunction

	function automatic int count_kind(input spw_char_e k);
		int n;
		n = 0;
		foreach (kind_q[i])
			if (kind_q[i] == k)
				n++;
		return n;
	endfunction

	function automatic int count_nchars();
		return count_kind(CHAR_DATA) + count_kind(CHAR_EOP) + count_kind(CHAR_EEP);
	endfunction

	// --------------------------------------------------
	// DS decoder
	// --------------------------------------------------
	task automatic push_char(input spw_char_e k, input logic [7:0] b);
		kind_q.push_back(k);
		byte_q.push_back(b);
		char_total++;
	endtask

	task automatic decode_bit(input logic b);
		cbuf[nbits] = b;
		nbits++;
		if (nbits == 2)
		begin
			flag = cbuf[1];
			need = flag ? int'(CHAR_LEN_CTRL) : int'(CHAR_LEN_DATA);
			// Previous data bits, parity and flag hold an odd count of ones
			check_bit("parity", cbuf[0], ~(run_par ^ flag));
		end
		else if (nbits == need)
		begin
			nbits = 0;
			if (!flag)
			begin
				if (esc_seen)
					report_failure("ESC was followed by a data character");
				esc_seen = 1'b0;
				run_par = ^cbuf[9:2];
				push_char(CHAR_DATA, cbuf[9:2]);
			end
			else
			begin
				code = cbuf[3:2];
				run_par = ^code;
				if (esc_seen)
				begin
					esc_seen = 1'b0;
					if (code == CTRL_FCT)
						push_char(CHAR_NULL, 8'h00);
					else
						report_failure("ESC was not followed by FCT");
				end
				else if (code == CTRL_ESC)
					esc_seen = 1'b1;
				else if (code == CTRL_FCT)
					push_char(CHAR_FCT, 8'h00);
				else if (code == CTRL_EOP)
					push_char(CHAR_EOP, 8'h00);
				else
					push_char(CHAR_EEP, 8'h00);
			end
		end
	endtask

	always @(negedge pclk_tx)
	begin
		if (!decode_en)
		begin
			started = 1'b0;
			esc_seen = 1'b0;
			run_par = 1'b0;
			nbits = 0;
			need = 0;
		end
		else
		begin
			d_chg = (tx_dout_o != prev_d);
			s_chg = (tx_sout_o != prev_s);
			// Back to back characters move one line on every bit
			if (started || d_chg || s_chg)
				check_bit("ds_single_change", d_chg ^ s_chg, 1'b1);
			if (d_chg ^ s_chg)
			begin
				started = 1'b1;
				decode_bit(tx_dout_o);
			end
		end
		prev_d = tx_dout_o;
		prev_s = tx_sout_o;
	end

	always @(posedge pclk_tx)
	begin
		if (ready_tx_data_o === 1'b1)
			ready_cnt++;
	end

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------
	task automatic idle_gap();
		repeat ($urandom % 6 + 1) @(negedge pclk_tx);
	endtask

	task automatic clear_chars();
		@(posedge pclk_tx);
		kind_q.delete();
		byte_q.delete();
		@(negedge pclk_tx);
	endtask

	task automatic wait_chars(input int n);
		int target;
		int cycles;
		@(posedge pclk_tx);
		target = char_total + n;
		cycles = 0;
		while (char_total < target && cycles < n * 2 * int'(CHAR_LEN_DATA) + 20)
		begin
			@(posedge pclk_tx);
			cycles++;
		end
		if (char_total < target)
			report_failure($sformatf("timed out waiting for %0d characters", n));
	endtask

	task automatic wait_ready(input int base, input int n, input int limit);
		int cycles;
		cycles = 0;
		while (ready_cnt - base < n && cycles < limit)
		begin
			@(negedge pclk_tx);
			cycles++;
		end
		if (ready_cnt - base < n)
			report_failure($sformatf("timed out waiting for ready pulse %0d", n));
	endtask

	task automatic pulse_gotfct(input int n);
		repeat (n)
		begin
			@(negedge pclk_tx);
			gotfct_tx_i = 1'b1;
			@(negedge pclk_tx);
			gotfct_tx_i = 1'b0;
		end
	endtask

	task automatic pulse_fct_request(input int n, input int width);
		repeat (n)
		begin
			@(negedge pclk_tx);
			send_fct_now_i = 1'b1;
			repeat (width) @(negedge pclk_tx);
			send_fct_now_i = 1'b0;
		end
	endtask

	task automatic expect_nchars(input int base, input int n);
		wait_ready(base, n, n * 4 * int'(CHAR_LEN_DATA) + 40);
		wait_chars(6);
		check_count("n-chars sent", to_count(count_nchars()), to_count(n));
		@(negedge pclk_tx);
		check_count("ready_tx_data_o pulses", to_count(ready_cnt - base), to_count(n));
	endtask

	task automatic end_test(input string name, input int start);
		if (error_count == start)
		begin
			tests_passed++;
			$display("test %s finished: pass", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s finished: %0d errors", name, error_count - start);
		end
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic test_reset();
		int start;
		int rdy;
		start = error_count;
		rdy = ready_cnt;
		repeat (20)
		begin
			@(negedge pclk_tx);
			check_bit("tx_dout_o", tx_dout_o, 1'b0);
			check_bit("tx_sout_o", tx_sout_o, 1'b0);
		end
		check_count("ready_tx_data_o pulses", to_count(ready_cnt - rdy), to_count(0));
		end_test("reset", start);
	endtask

	task automatic test_null_stream();
		int start;
		start = error_count;
		@(negedge pclk_tx);
		decode_en = 1'b1;
		clear_chars();
		send_null_tx_i = 1'b1;
		wait_chars(16);
		foreach (kind_q[i])
			check_kind("decoded kind", kind_q[i], CHAR_NULL);
		end_test("null_stream", start);
	endtask

	task automatic test_fct_request();
		int start;
		start = error_count;
		// Requests pile up in NULLS where no FCT may go out
		pulse_fct_request(8, 1);
		clear_chars();
		send_fct_tx_i = 1'b1;
		wait_chars(14);
		check_count("fct after eight requests", to_count(count_kind(CHAR_FCT)), to_count(7));
		clear_chars();
		pulse_fct_request(1, 1);
		wait_chars(4);
		check_count("fct after one pulse", to_count(count_kind(CHAR_FCT)), to_count(1));
		clear_chars();
		pulse_fct_request(1, 24);
		wait_chars(4);
		check_count("fct after held level", to_count(count_kind(CHAR_FCT)), to_count(1));
		end_test("fct_request", start);
	endtask

	task automatic test_nchar_content();
		logic [NCHAR_W-1:0] words [0:7];
		spw_char_e          kinds [0:7];
		int start;
		int base;
		int j;
		words = '{9'h0A5, 9'h03C, 9'h100, 9'h0FF, 9'h101, 9'h000, 9'h05A, 9'h100};
		// Bit 8 with low bits 00 is EOP, with 01 is EEP
		kinds = '{CHAR_DATA, CHAR_DATA, CHAR_EOP, CHAR_DATA,
		          CHAR_EEP, CHAR_DATA, CHAR_DATA, CHAR_EOP};
		start = error_count;
		clear_chars();
		pulse_gotfct(1);
		base = ready_cnt;
		for (int i = 0; i < 8; i++)
		begin
			data_tx_i = words[i];
			txwrite_tx_i = 1'b1;
			wait_ready(base, i + 1, 4 * int'(CHAR_LEN_DATA));
		end
		txwrite_tx_i = 1'b0;
		wait_chars(2);
		j = 0;
		foreach (kind_q[i])
		begin
			if (kind_q[i] != CHAR_NULL && j < 8)
			begin
				check_kind("n-char kind", kind_q[i], kinds[j]);
				if (kinds[j] == CHAR_DATA)
					check_byte("data byte", byte_q[i], words[j][7:0]);
				j++;
			end
		end
		check_count("n-chars sent", to_count(count_nchars()), to_count(8));
		@(negedge pclk_tx);
		check_count("ready_tx_data_o pulses", to_count(ready_cnt - base), to_count(8));
		end_test("nchar_content", start);
	endtask

	task automatic test_credit();
		int start;
		int base;
		start = error_count;
		clear_chars();
		data_tx_i = 9'h0C3;
		txwrite_tx_i = 1'b1;
		base = ready_cnt;
		pulse_gotfct(1);
		expect_nchars(base, 8);
		clear_chars();
		base = ready_cnt;
		pulse_gotfct(1);
		expect_nchars(base, 8);
		// Eight pulses would give 64 credits but the ceiling holds 56
		txwrite_tx_i = 1'b0;
		pulse_gotfct(8);
		clear_chars();
		base = ready_cnt;
		txwrite_tx_i = 1'b1;
		expect_nchars(base, 56);
		txwrite_tx_i = 1'b0;
		end_test("credit", start);
	endtask

	task automatic test_link_drop();
		int start;
		int rdy;
		start = error_count;
		@(negedge pclk_tx);
		decode_en = 1'b0;
		send_null_tx_i = 1'b0;
		rdy = ready_cnt;
		@(posedge pclk_tx);
		@(posedge pclk_tx);
		@(negedge pclk_tx);
		repeat (10)
		begin
			check_bit("tx_dout_o", tx_dout_o, 1'b0);
			check_bit("tx_sout_o", tx_sout_o, 1'b0);
			@(negedge pclk_tx);
		end
		check_count("ready_tx_data_o pulses", to_count(ready_cnt - rdy), to_count(0));
		end_test("link_drop", start);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		seed_val = $urandom(23);
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		char_total = 0;
		ready_cnt = 0;
		decode_en = 1'b0;
		enable_tx = 1'b0;
		data_tx_i = '0;
		txwrite_tx_i = 1'b0;
		send_null_tx_i = 1'b0;
		send_fct_tx_i = 1'b0;
		gotfct_tx_i = 1'b0;
		send_fct_now_i = 1'b0;
		repeat (2) @(posedge pclk_tx);
		@(negedge pclk_tx);
		enable_tx = 1'b1;
		test_reset();
		idle_gap();
		test_null_stream();
		idle_gap();
		test_fct_request();
		idle_gap();
		test_nchar_content();
		idle_gap();
		test_credit();
		idle_gap();
		test_link_drop();
		$display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
		if (error_count == 0 && tests_failed == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: spw_tx.f
hw/spw_tx_pkg.sv
hw/spw_tx_link_fsm.sv
hw/spw_tx_credit.sv
hw/spw_tx_char_select.sv
hw/spw_tx_serializer.sv
hw/spw_tx_ds_encoder.sv
hw/spw_tx.sv
verification/tb_spw_tx.sv
